// ==== Makefile ====
SIM      := verilator
TOP      := tb_ex_cluster
FILELIST := sources.f
FLAGS    := --binary --timing --assert --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_ex_cluster.sv ====
`timescale 1ns/1ps
`include "ex_macros.svh"

module tb_ex_cluster;

    import ex_pkg::*;

    localparam int RST_CYCLES = 16;
    localparam int N_ALU      = 120;
    localparam int N_BR       = 60;
    localparam int N_MIX      = 80;
    localparam int N_OPS      = 1 + 15 + N_ALU + N_BR + N_MIX + 5;

    logic               cpu_clock = 1'b0;
    logic               rst;
    logic               flush;
    logic               valid;
    logic               ready;
    logic [`ROB_W-1:0]  rob_id;
    logic [4:0]         ins_type;
    ex_opc_u            opc;
    logic               imm_sel;
    logic [`XLEN_W-1:0] immediate;
    logic [`PREG_W-1:0] rs1, rs2, dest;
    logic [`PC_W-1:0]   pc, btb_target;
    logic [1:0]         bm_pred;
    logic               btb_vld;
    logic               wakeup_valid;
    logic [`PREG_W-1:0] wakeup_dest;
    logic               cmpl_valid, cmpl_wr, cmpl_redirect;
    logic [`ROB_W-1:0]  cmpl_rob;
    logic [`PREG_W-1:0] cmpl_dest;
    logic [`XLEN_W-1:0] cmpl_data;
    logic [`PC_W-1:0]   cmpl_target;

    // Staged micro-op, filled by the builder tasks before it is sent
    logic [4:0]         s_type;
    ex_opc_u            s_opc;
    logic               s_imm_sel;
    logic [`XLEN_W-1:0] s_imm;
    logic [`PREG_W-1:0] s_rs1, s_rs2, s_dest;
    logic [`PC_W-1:0]   s_pc, s_btbt;
    logic [1:0]         s_bm;
    logic               s_btbv;

    logic [`XLEN_W-1:0] shadow     [2**`PREG_W];
    logic               pending    [2**`ROB_W];
    logic               is_alu     [2**`ROB_W];
    logic               exp_wr     [2**`ROB_W];
    logic               exp_redir  [2**`ROB_W];
    logic [`PREG_W-1:0] exp_dest   [2**`ROB_W];
    logic [`XLEN_W-1:0] exp_data   [2**`ROB_W];
    logic [`PC_W-1:0]   exp_target [2**`ROB_W];
    int                 acc_cyc    [2**`ROB_W];
    logic [`ROB_W-1:0]  alu_order  [$];
    logic [`ROB_W-1:0]  next_tag = '0;
    int                 outstanding = 0;
    int                 cyc = 0;
    logic               prev_wr = 1'b0;
    logic [`PREG_W-1:0] prev_dest = '0;
    logic [31:0]        lcg = 32'd25103;
    logic [2:0]         conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    always #4 cpu_clock = ~cpu_clock;

    ex_cluster_top dut0 (
        .cpu_clock_i(cpu_clock), .rst_i(rst), .flush_i(flush), .valid_i(valid),
        .ready_o(ready), .rob_id_i(rob_id), .ins_type_i(ins_type), .opc_i(opc),
        .imm_sel_i(imm_sel), .immediate_i(immediate), .rs1_i(rs1), .rs2_i(rs2),
        .dest_i(dest), .pc_i(pc), .bm_pred_i(bm_pred), .btb_vld_i(btb_vld),
        .btb_target_i(btb_target), .wakeup_valid_o(wakeup_valid),
        .wakeup_dest_o(wakeup_dest), .cmpl_valid_o(cmpl_valid), .cmpl_rob_o(cmpl_rob),
        .cmpl_dest_o(cmpl_dest), .cmpl_wr_o(cmpl_wr), .cmpl_data_o(cmpl_data),
        .cmpl_redirect_o(cmpl_redirect), .cmpl_target_o(cmpl_target)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_random();
        lcg = lcg * 32'd1664525 + 32'd1013904223;
        return lcg;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] word;
        word = next_random();
        return int'(word % 32'(n));
    endfunction

    function automatic logic [`PREG_W-1:0] pick_src();
        int r;
        r = rand_below(17);
        if (r == 16) begin
            r = 63;                                 // Register 63 is never written
        end
        return r[`PREG_W-1:0];
    endfunction

    function automatic logic [`PREG_W-1:0] pick_dest();
        int r;
        r = 16 + rand_below(47);                    // Results go to 16..62 and are never read
        return r[`PREG_W-1:0];
    endfunction

    function automatic logic [`XLEN_W-1:0] alu_ref(input logic [`XLEN_W-1:0] a, b,
                                                   input logic alt, input logic [2:0] f3);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic cond_ref(input logic [2:0] c, input logic [`XLEN_W-1:0] a, b);
        case (c)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Actual next word PC of the staged micro-op
    function automatic logic [`PC_W-1:0] next_pc_ref();
        logic [`XLEN_W-1:0] a, b, sum, quarter;
        logic [`PC_W-1:0]   step;
        a = shadow[s_rs1];
        b = shadow[s_rs2];
        quarter = $signed(s_imm) >>> 2;
        step = quarter[`PC_W-1:0];
        sum = a + s_imm;
        case (s_type)
            5'b00010: return s_pc + step;
            5'b00100: return sum[`XLEN_W-1:2];
            5'b00000: return cond_ref(s_opc.bnch.cond, a, b) ? s_pc + step : s_pc + 1'b1;
            default: return s_pc + 1'b1;
        endcase
    endfunction

    task automatic make_alu();
        logic [31:0] word;
        word = next_random();
        s_type = 5'b00001;
        s_opc = '0;
        s_opc.alu.alt = word[0];
        s_opc.alu.funct3 = word[3:1];
        s_imm_sel = word[4];
        s_bm = word[6:5];
        s_btbv = word[7];
        s_rs1 = pick_src();
        s_rs2 = pick_src();
        s_dest = pick_dest();
        s_imm = next_random();
        word = next_random();
        s_pc = word[`PC_W-1:0];
        s_btbt = '0;
    endtask

    // Kinds 0 to 5 are conditional branches, then JAL, JALR, AUIPC and LUI
    task automatic make_branch(input int kind);
        logic [31:0] word;
        s_opc = '0;
        s_imm_sel = 1'b0;
        s_rs1 = pick_src();
        s_rs2 = (rand_below(4) == 0) ? s_rs1 : pick_src();
        s_dest = pick_dest();
        s_imm = next_random();
        word = next_random();
        s_pc = word[`PC_W-1:0];
        s_bm = word[31:30];
        s_btbv = (rand_below(4) != 0);
        word = next_random();
        s_btbt = word[`PC_W-1:0];
        case (kind)
            6: s_type = 5'b00010;
            7: s_type = 5'b00100;
            8: s_type = 5'b10000;
            9: s_type = 5'b01000;
            default: begin
                s_type = 5'b00000;
                s_opc.bnch.cond = conds[kind];
            end
        endcase
        if (rand_below(2) == 0) begin
            s_btbt = next_pc_ref();                 // Half of the hints point at the real target
        end
    endtask

    task automatic send_op(input logic do_flush);
        logic [`ROB_W-1:0]  tag;
        logic [`XLEN_W-1:0] a, b;
        logic [`PC_W-1:0]   pred_next;
        tag = next_tag;
        next_tag = next_tag + 1'b1;
        a = shadow[s_rs1];
        b = s_imm_sel ? s_imm : shadow[s_rs2];
        pred_next = (s_btbv && (s_bm[1] || s_type[1] || s_type[2])) ? s_btbt : s_pc + 1'b1;
        @(negedge cpu_clock);
        valid = 1'b1;
        flush = do_flush;
        rob_id = tag;
        ins_type = s_type;
        opc = s_opc;
        imm_sel = s_imm_sel;
        immediate = s_imm;
        rs1 = s_rs1;
        rs2 = s_rs2;
        dest = s_dest;
        pc = s_pc;
        bm_pred = s_bm;
        btb_vld = s_btbv;
        btb_target = s_btbt;
        if (!do_flush) begin
            while (!ready) begin
                @(negedge cpu_clock);               // Hold the micro-op until it is taken
            end
            is_alu[tag] = s_type[0];
            exp_wr[tag] = (s_type != 5'd0);
            exp_dest[tag] = s_dest;
            exp_target[tag] = next_pc_ref();
            exp_redir[tag] = !s_type[0] && (exp_target[tag] != pred_next);
            case (s_type)
                5'b00001: exp_data[tag] = alu_ref(a, b, s_opc.alu.alt, s_opc.alu.funct3);
                5'b01000: exp_data[tag] = s_imm;
                5'b10000: exp_data[tag] = {s_pc, 2'b00} + s_imm;
                5'b00000: exp_data[tag] = '0;
                default: exp_data[tag] = {s_pc + 1'b1, 2'b00};
            endcase
            if (exp_wr[tag] && s_dest != '0) begin
                shadow[s_dest] = exp_data[tag];
            end
            if (s_type[0]) begin
                alu_order.push_back(tag);
            end
            acc_cyc[tag] = cyc + 1;
            pending[tag] = 1'b1;
            outstanding++;
        end
        @(posedge cpu_clock);
    endtask

    task automatic drain();
        @(negedge cpu_clock);
        valid = 1'b0;
        flush = 1'b0;
        while (outstanding != 0) begin
            @(negedge cpu_clock);
        end
    endtask

    task automatic check_completion();
        logic [`ROB_W-1:0] t;
        t = cmpl_rob;
        assert (pending[t])
            else report_failure($sformatf("ROB tag %0d completed but was not outstanding", t));
        if (is_alu[t]) begin
            assert (alu_order.size() != 0 && alu_order[0] == t)
                else report_failure($sformatf("ALU result of ROB tag %0d is out of order", t));
            void'(alu_order.pop_front());
            assert (cyc - acc_cyc[t] >= 2)
                else report_failure($sformatf("ALU result of ROB tag %0d came too early", t));
        end else begin
            assert (cyc - acc_cyc[t] == 2)
                else report_failure($sformatf("ROB tag %0d completed %0d cycles after issue",
                                              t, cyc - acc_cyc[t]));
            assert (cmpl_target == exp_target[t])
                else report_failure($sformatf("Mismatch cmpl_target_o: got %h expected %h",
                                              cmpl_target, exp_target[t]));
        end
        assert (cmpl_wr == exp_wr[t])
            else report_failure($sformatf("Mismatch cmpl_wr_o: got %h expected %h",
                                          cmpl_wr, exp_wr[t]));
        if (exp_wr[t]) begin
            assert (cmpl_dest == exp_dest[t])
                else report_failure($sformatf("Mismatch cmpl_dest_o: got %h expected %h",
                                              cmpl_dest, exp_dest[t]));
            assert (cmpl_data == exp_data[t])
                else report_failure($sformatf("Mismatch cmpl_data_o: got %h expected %h",
                                              cmpl_data, exp_data[t]));
        end
        assert (cmpl_redirect == exp_redir[t])
            else report_failure($sformatf("Mismatch cmpl_redirect_o: got %h expected %h",
                                          cmpl_redirect, exp_redir[t]));
        pending[t] = 1'b0;
        outstanding--;
    endtask

    always @(posedge cpu_clock) begin
        if (rst) begin
            prev_wr = 1'b0;
        end else begin
            assert (wakeup_valid == prev_wr)
                else report_failure($sformatf("Mismatch wakeup_valid_o: got %h expected %h",
                                              wakeup_valid, prev_wr));
            if (prev_wr) begin
                assert (wakeup_dest == prev_dest)
                    else report_failure($sformatf("Mismatch wakeup_dest_o: got %h expected %h",
                                                  wakeup_dest, prev_dest));
            end
            if (cmpl_valid) begin
                check_completion();
            end
            prev_wr = valid && ready && !flush && (ins_type != 5'd0);
            prev_dest = dest;
        end
        cyc = cyc + 1;
    end

    assert property (@(posedge cpu_clock) disable iff (rst) (valid && flush) |=> !wakeup_valid)
        else report_failure("A flushed micro-op produced a wakeup");

    assert property (@(posedge cpu_clock) disable iff (rst) (valid && !ready) |=> !wakeup_valid)
        else report_failure("A micro-op was taken while ready_o was low");

    initial begin
        repeat (RST_CYCLES + 200 * N_OPS) @(posedge cpu_clock);
        report_failure("Simulation timed out before all micro-ops completed");
    end

    initial begin
        for (int i = 0; i < 2**`PREG_W; i++) begin
            shadow[i] = '0;
        end
        for (int i = 0; i < 2**`ROB_W; i++) begin
            pending[i] = 1'b0;
            is_alu[i] = 1'b0;
        end
        rst = 1'b1;
        flush = 1'b0;
        valid = 1'b0;
        rob_id = '0;
        ins_type = '0;
        opc = '0;
        imm_sel = 1'b0;
        immediate = '0;
        rs1 = '0;
        rs2 = '0;
        dest = '0;
        pc = '0;
        bm_pred = '0;
        btb_vld = 1'b0;
        btb_target = '0;
        repeat (RST_CYCLES) @(posedge cpu_clock);
        @(negedge cpu_clock);
        rst = 1'b0;
        assert (ready && !cmpl_valid && !wakeup_valid)
            else report_failure("Outputs are not in their reset state after reset");

        make_alu();                                 // OR of two registers that were never written
        s_rs1 = 6'd5;
        s_rs2 = 6'd9;
        s_imm_sel = 1'b0;
        s_opc.alu.funct3 = 3'd6;
        send_op(1'b0);
        drain();

        for (int r = 1; r < 16; r++) begin
            make_branch(9);
            s_dest = r[`PREG_W-1:0];
            s_btbv = 1'b0;
            s_bm = 2'b00;
            send_op(1'b0);
        end
        drain();

        repeat (N_ALU) begin
            make_alu();
            send_op(1'b0);
        end
        drain();

        repeat (N_BR) begin
            make_branch(rand_below(10));
            send_op(1'b0);
        end
        drain();

        repeat (N_MIX) begin
            if (rand_below(2) == 0) begin
                make_alu();
            end else begin
                make_branch(rand_below(10));
            end
            send_op(1'b0);
        end
        drain();

        make_alu();
        send_op(1'b0);
        drain();
        make_alu();
        send_op(1'b1);
        make_branch(6);
        send_op(1'b0);
        drain();
        make_branch(6);
        send_op(1'b1);
        make_alu();
        send_op(1'b0);
        drain();

        if (outstanding == 0 && alu_order.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            report_failure("Micro-ops are still outstanding at the end of the run");
        end
    end

endmodule

// ==== include/ex_macros.svh ====
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// Data path width
`define XLEN_W 32

// Physical register index, 64 registers
`define PREG_W 6

// ROB tag width
`define ROB_W 5

// Word address PC, byte PC is this value with two zero bits appended
`define PC_W 30

// Depth of the ALU result queue in the completion merger
`define CQ_DEPTH 4

`endif

// ==== sources.f ====
+incdir+include
verilog/ex_pkg.sv
verilog/ex_regfile.sv
verilog/ex_dispatch.sv
verilog/ex_alu.sv
verilog/ex_branch.sv
verilog/ex_complete.sv
verilog/ex_cluster_top.sv
bench/tb_ex_cluster.sv

// ==== verilog/ex_alu.sv ====
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_alu (
    input  logic               cpu_clock_i,
    input  logic               rst_i,
    input  logic               flush_i,
    input  logic               valid_i,
    input  logic [`XLEN_W-1:0] a_i,
    input  logic [`XLEN_W-1:0] b_i,
    input  ex_pkg::ex_opc_u    opc_i,
    input  logic [`ROB_W-1:0]  rob_i,
    input  logic [`PREG_W-1:0] dest_i,
    output logic               valid_o,
    output logic [`ROB_W-1:0]  rob_o,
    output logic [`PREG_W-1:0] dest_o,
    output logic [`XLEN_W-1:0] result_o
);

    logic [4:0]         shamt;
    logic [`XLEN_W-1:0] res;

    assign shamt = b_i[4:0];

    always_comb begin
        case (opc_i.alu.funct3)
            3'd0: res = opc_i.alu.alt ? (a_i - b_i) : (a_i + b_i);
            3'd1: res = a_i << shamt;
            3'd2: res = {31'd0, $signed(a_i) < $signed(b_i)};
            3'd3: res = {31'd0, a_i < b_i};
            3'd4: res = a_i ^ b_i;
            3'd5: res = opc_i.alu.alt ? $unsigned($signed(a_i) >>> shamt) : (a_i >> shamt);
            3'd6: res = a_i | b_i;
            default: res = a_i & b_i;
        endcase
    end

    always_ff @(posedge cpu_clock_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i & ~flush_i;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        rob_o    <= rob_i;
        dest_o   <= dest_i;
        result_o <= res;
    end

endmodule

// ==== verilog/ex_branch.sv ====
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_branch (
    input  logic               cpu_clock_i,
    input  logic               rst_i,
    input  logic               flush_i,
    input  logic               valid_i,
    input  logic [`XLEN_W-1:0] op1_i,
    input  logic [`XLEN_W-1:0] op2_i,
    input  logic [`XLEN_W-1:0] offset_i,
    input  logic [`PC_W-1:0]   pc_i,
    input  logic [4:0]         type_i,
    input  ex_pkg::ex_opc_u    opc_i,
    input  logic [`ROB_W-1:0]  rob_i,
    input  logic [`PREG_W-1:0] dest_i,
    input  logic               pred_taken_i,
    input  logic [`PC_W-1:0]   pred_target_i,
    output logic               valid_o,
    output logic [`ROB_W-1:0]  rob_o,
    output logic [`PREG_W-1:0] dest_o,
    output logic               wr_o,
    output logic [`XLEN_W-1:0] result_o,
    output logic               redirect_o,
    output logic [`PC_W-1:0]   target_o
);

    logic [`PC_W-1:0]   pc_plus1;
    logic [`PC_W-1:0]   pc_offs;
    logic [`XLEN_W-1:0] jalr_sum;
    logic               cond_taken;
    logic [`PC_W-1:0]   next_pc;
    logic [`PC_W-1:0]   pred_next;
    logic [`XLEN_W-1:0] res;

    assign pc_plus1 = pc_i + 1'b1;
    assign pc_offs  = pc_i + offset_i[`XLEN_W-1:2];     // Offset is a byte offset
    assign jalr_sum = op1_i + offset_i;

    always_comb begin
        case (opc_i.bnch.cond)
            3'd0: cond_taken = (op1_i == op2_i);
            3'd1: cond_taken = (op1_i != op2_i);
            3'd4: cond_taken = ($signed(op1_i) < $signed(op2_i));
            3'd5: cond_taken = ($signed(op1_i) >= $signed(op2_i));
            3'd6: cond_taken = (op1_i < op2_i);
            3'd7: cond_taken = (op1_i >= op2_i);
            default: cond_taken = 1'b0;
        endcase
    end

    always_comb begin
        if (type_i[1]) begin
            next_pc = pc_offs;
        end else if (type_i[2]) begin
            next_pc = jalr_sum[`XLEN_W-1:2];
        end else if (type_i == 5'd0) begin
            next_pc = cond_taken ? pc_offs : pc_plus1;
        end else begin
            next_pc = pc_plus1;                    // LUI and AUIPC fall through
        end
    end

    always_comb begin
        if (type_i[3]) begin
            res = offset_i;
        end else if (type_i[4]) begin
            res = {pc_i, 2'b00} + offset_i;
        end else begin
            res = {pc_plus1, 2'b00};               // Link value for JAL and JALR
        end
    end

    assign pred_next = pred_taken_i ? pred_target_i : pc_plus1;

    always_ff @(posedge cpu_clock_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i & ~flush_i;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        rob_o      <= rob_i;
        dest_o     <= dest_i;
        wr_o       <= |type_i;
        result_o   <= res;
        redirect_o <= (next_pc != pred_next);
        target_o   <= next_pc;
    end

endmodule

// ==== verilog/ex_cluster_top.sv ====
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_cluster_top (
    input  logic               cpu_clock_i,
    input  logic               rst_i,
    input  logic               flush_i,
    input  logic               valid_i,
    output logic               ready_o,
    input  logic [`ROB_W-1:0]  rob_id_i,
    input  logic [4:0]         ins_type_i,
    input  ex_pkg::ex_opc_u    opc_i,
    input  logic               imm_sel_i,
    input  logic [`XLEN_W-1:0] immediate_i,
    input  logic [`PREG_W-1:0] rs1_i,
    input  logic [`PREG_W-1:0] rs2_i,
    input  logic [`PREG_W-1:0] dest_i,
    input  logic [`PC_W-1:0]   pc_i,
    input  logic [1:0]         bm_pred_i,
    input  logic               btb_vld_i,
    input  logic [`PC_W-1:0]   btb_target_i,
    output logic               wakeup_valid_o,
    output logic [`PREG_W-1:0] wakeup_dest_o,
    output logic               cmpl_valid_o,
    output logic [`ROB_W-1:0]  cmpl_rob_o,
    output logic [`PREG_W-1:0] cmpl_dest_o,
    output logic               cmpl_wr_o,
    output logic [`XLEN_W-1:0] cmpl_data_o,
    output logic               cmpl_redirect_o,
    output logic [`PC_W-1:0]   cmpl_target_o
);

    logic [`PREG_W-1:0] rs1_idx, rs2_idx;
    logic [`XLEN_W-1:0] rs1_data, rs2_data;
    logic               alu_valid, alu_res_valid;
    logic [`XLEN_W-1:0] alu_a, alu_b, alu_result;
    ex_pkg::ex_opc_u    alu_opc, bnch_opc;
    logic [`ROB_W-1:0]  alu_rob, alu_res_rob, bnch_rob, bnch_res_rob;
    logic [`PREG_W-1:0] alu_dest, alu_res_dest, bnch_dest, bnch_res_dest;
    logic               bnch_valid, bnch_res_valid, bnch_pred_taken;
    logic [`XLEN_W-1:0] bnch_op1, bnch_op2, bnch_offset, bnch_result;
    logic [`PC_W-1:0]   bnch_pc, bnch_pred_target, bnch_target;
    logic [4:0]         bnch_type;
    logic               bnch_wr, bnch_redirect;

    ex_regfile u_regfile (
        .cpu_clock_i(cpu_clock_i), .rst_i(rst_i),
        .rd1_idx_i(rs1_idx), .rd2_idx_i(rs2_idx),
        .rd1_data_o(rs1_data), .rd2_data_o(rs2_data),
        .wr_en_i(cmpl_valid_o & cmpl_wr_o),        // Written from the completion port
        .wr_idx_i(cmpl_dest_o), .wr_data_i(cmpl_data_o)
    );

    ex_dispatch u_dispatch (
        .cpu_clock_i(cpu_clock_i), .rst_i(rst_i), .flush_i(flush_i),
        .valid_i(valid_i), .ready_i(ready_o), .rob_id_i(rob_id_i),
        .ins_type_i(ins_type_i), .opc_i(opc_i), .imm_sel_i(imm_sel_i),
        .immediate_i(immediate_i), .rs1_i(rs1_i), .rs2_i(rs2_i), .dest_i(dest_i),
        .pc_i(pc_i), .bm_pred_i(bm_pred_i), .btb_vld_i(btb_vld_i),
        .btb_target_i(btb_target_i), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .rs1_o(rs1_idx), .rs2_o(rs2_idx),
        .alu_valid_o(alu_valid), .alu_a_o(alu_a), .alu_b_o(alu_b),
        .alu_opc_o(alu_opc), .alu_rob_o(alu_rob), .alu_dest_o(alu_dest),
        .bnch_valid_o(bnch_valid), .bnch_op1_o(bnch_op1), .bnch_op2_o(bnch_op2),
        .bnch_offset_o(bnch_offset), .bnch_pc_o(bnch_pc), .bnch_type_o(bnch_type),
        .bnch_opc_o(bnch_opc), .bnch_rob_o(bnch_rob), .bnch_dest_o(bnch_dest),
        .bnch_pred_taken_o(bnch_pred_taken), .bnch_pred_target_o(bnch_pred_target),
        .wakeup_valid_o(wakeup_valid_o), .wakeup_dest_o(wakeup_dest_o)
    );

    ex_alu u_alu (
        .cpu_clock_i(cpu_clock_i), .rst_i(rst_i), .flush_i(flush_i),
        .valid_i(alu_valid), .a_i(alu_a), .b_i(alu_b), .opc_i(alu_opc),
        .rob_i(alu_rob), .dest_i(alu_dest), .valid_o(alu_res_valid),
        .rob_o(alu_res_rob), .dest_o(alu_res_dest), .result_o(alu_result)
    );

    ex_branch u_branch (
        .cpu_clock_i(cpu_clock_i), .rst_i(rst_i), .flush_i(flush_i),
        .valid_i(bnch_valid), .op1_i(bnch_op1), .op2_i(bnch_op2),
        .offset_i(bnch_offset), .pc_i(bnch_pc), .type_i(bnch_type), .opc_i(bnch_opc),
        .rob_i(bnch_rob), .dest_i(bnch_dest), .pred_taken_i(bnch_pred_taken),
        .pred_target_i(bnch_pred_target), .valid_o(bnch_res_valid),
        .rob_o(bnch_res_rob), .dest_o(bnch_res_dest), .wr_o(bnch_wr),
        .result_o(bnch_result), .redirect_o(bnch_redirect), .target_o(bnch_target)
    );

    ex_complete u_complete (
        .cpu_clock_i(cpu_clock_i), .rst_i(rst_i),
        .alu_valid_i(alu_res_valid), .alu_rob_i(alu_res_rob),
        .alu_dest_i(alu_res_dest), .alu_result_i(alu_result),
        .bnch_valid_i(bnch_res_valid), .bnch_rob_i(bnch_res_rob),
        .bnch_dest_i(bnch_res_dest), .bnch_wr_i(bnch_wr), .bnch_result_i(bnch_result),
        .bnch_redirect_i(bnch_redirect), .bnch_target_i(bnch_target),
        .ready_o(ready_o), .cmpl_valid_o(cmpl_valid_o), .cmpl_rob_o(cmpl_rob_o),
        .cmpl_dest_o(cmpl_dest_o), .cmpl_wr_o(cmpl_wr_o), .cmpl_data_o(cmpl_data_o),
        .cmpl_redirect_o(cmpl_redirect_o), .cmpl_target_o(cmpl_target_o)
    );

endmodule

// ==== verilog/ex_complete.sv ====
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_complete (
    input  logic               cpu_clock_i,
    input  logic               rst_i,
    input  logic               alu_valid_i,
    input  logic [`ROB_W-1:0]  alu_rob_i,
    input  logic [`PREG_W-1:0] alu_dest_i,
    input  logic [`XLEN_W-1:0] alu_result_i,
    input  logic               bnch_valid_i,
    input  logic [`ROB_W-1:0]  bnch_rob_i,
    input  logic [`PREG_W-1:0] bnch_dest_i,
    input  logic               bnch_wr_i,
    input  logic [`XLEN_W-1:0] bnch_result_i,
    input  logic               bnch_redirect_i,
    input  logic [`PC_W-1:0]   bnch_target_i,
    output logic               ready_o,
    output logic               cmpl_valid_o,
    output logic [`ROB_W-1:0]  cmpl_rob_o,
    output logic [`PREG_W-1:0] cmpl_dest_o,
    output logic               cmpl_wr_o,
    output logic [`XLEN_W-1:0] cmpl_data_o,
    output logic               cmpl_redirect_o,
    output logic [`PC_W-1:0]   cmpl_target_o
);

    localparam int PTR_W = $clog2(`CQ_DEPTH);

    logic [`ROB_W-1:0]  q_rob  [`CQ_DEPTH];
    logic [`PREG_W-1:0] q_dest [`CQ_DEPTH];
    logic [`XLEN_W-1:0] q_data [`CQ_DEPTH];
    logic [PTR_W-1:0]   head;
    logic [PTR_W-1:0]   tail;
    logic [PTR_W:0]     count;
    logic               use_head;
    logic               use_alu;
    logic               push;

    assign use_head = ~bnch_valid_i & (count != '0);
    assign use_alu  = ~bnch_valid_i & (count == '0) & alu_valid_i;   // Empty queue is bypassed
    assign push     = alu_valid_i & ~use_alu;
    assign ready_o  = (count <= (`CQ_DEPTH - 2));

    always_ff @(posedge cpu_clock_i) begin
        if (rst_i) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            cmpl_valid_o <= 1'b0;
        end else begin
            head         <= head + PTR_W'(use_head);
            tail         <= tail + PTR_W'(push);
            count        <= count + (PTR_W+1)'(push) - (PTR_W+1)'(use_head);
            cmpl_valid_o <= bnch_valid_i | use_head | use_alu;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (push) begin
            q_rob[tail]  <= alu_rob_i;
            q_dest[tail] <= alu_dest_i;
            q_data[tail] <= alu_result_i;
        end
        if (bnch_valid_i) begin                    // Branch results never wait
            cmpl_rob_o      <= bnch_rob_i;
            cmpl_dest_o     <= bnch_dest_i;
            cmpl_wr_o       <= bnch_wr_i;
            cmpl_data_o     <= bnch_result_i;
            cmpl_redirect_o <= bnch_redirect_i;
            cmpl_target_o   <= bnch_target_i;
        end else begin
            cmpl_rob_o      <= use_head ? q_rob[head] : alu_rob_i;
            cmpl_dest_o     <= use_head ? q_dest[head] : alu_dest_i;
            cmpl_wr_o       <= 1'b1;
            cmpl_data_o     <= use_head ? q_data[head] : alu_result_i;
            cmpl_redirect_o <= 1'b0;
            cmpl_target_o   <= '0;
        end
    end

endmodule

// ==== verilog/ex_dispatch.sv ====
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_dispatch (
    input  logic               cpu_clock_i,
    input  logic               rst_i,
    input  logic               flush_i,
    input  logic               valid_i,
    input  logic               ready_i,
    input  logic [`ROB_W-1:0]  rob_id_i,
    input  logic [4:0]         ins_type_i,     // 0 ALU, 1 JAL, 2 JALR, 3 LUI, 4 AUIPC
    input  ex_pkg::ex_opc_u    opc_i,
    input  logic               imm_sel_i,
    input  logic [`XLEN_W-1:0] immediate_i,
    input  logic [`PREG_W-1:0] rs1_i,
    input  logic [`PREG_W-1:0] rs2_i,
    input  logic [`PREG_W-1:0] dest_i,
    input  logic [`PC_W-1:0]   pc_i,
    input  logic [1:0]         bm_pred_i,
    input  logic               btb_vld_i,
    input  logic [`PC_W-1:0]   btb_target_i,
    input  logic [`XLEN_W-1:0] rs1_data_i,
    input  logic [`XLEN_W-1:0] rs2_data_i,
    output logic [`PREG_W-1:0] rs1_o,
    output logic [`PREG_W-1:0] rs2_o,
    output logic               alu_valid_o,
    output logic [`XLEN_W-1:0] alu_a_o,
    output logic [`XLEN_W-1:0] alu_b_o,
    output ex_pkg::ex_opc_u    alu_opc_o,
    output logic [`ROB_W-1:0]  alu_rob_o,
    output logic [`PREG_W-1:0] alu_dest_o,
    output logic               bnch_valid_o,
    output logic [`XLEN_W-1:0] bnch_op1_o,
    output logic [`XLEN_W-1:0] bnch_op2_o,
    output logic [`XLEN_W-1:0] bnch_offset_o,
    output logic [`PC_W-1:0]   bnch_pc_o,
    output logic [4:0]         bnch_type_o,
    output ex_pkg::ex_opc_u    bnch_opc_o,
    output logic [`ROB_W-1:0]  bnch_rob_o,
    output logic [`PREG_W-1:0] bnch_dest_o,
    output logic               bnch_pred_taken_o,
    output logic [`PC_W-1:0]   bnch_pred_target_o,
    output logic               wakeup_valid_o,
    output logic [`PREG_W-1:0] wakeup_dest_o
);

    logic accept;
    logic pred_taken;

    assign accept     = valid_i & ready_i & ~flush_i;
    assign pred_taken = btb_vld_i & (bm_pred_i[1] | ins_type_i[1] | ins_type_i[2]);

    assign rs1_o = rs1_i;                          // Operands are read in the issue cycle
    assign rs2_o = rs2_i;

    always_ff @(posedge cpu_clock_i) begin
        if (rst_i) begin
            alu_valid_o    <= 1'b0;
            bnch_valid_o   <= 1'b0;
            wakeup_valid_o <= 1'b0;
        end else begin
            alu_valid_o    <= accept & ins_type_i[0];
            bnch_valid_o   <= accept & ~ins_type_i[0];
            wakeup_valid_o <= accept & (|ins_type_i);     // Conditional branches write nothing
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (accept) begin
            alu_a_o            <= rs1_data_i;
            alu_b_o            <= imm_sel_i ? immediate_i : rs2_data_i;
            alu_opc_o          <= opc_i;
            alu_rob_o          <= rob_id_i;
            alu_dest_o         <= dest_i;
            bnch_op1_o         <= rs1_data_i;
            bnch_op2_o         <= rs2_data_i;
            bnch_offset_o      <= immediate_i;
            bnch_pc_o          <= pc_i;
            bnch_type_o        <= ins_type_i;
            bnch_opc_o         <= opc_i;
            bnch_rob_o         <= rob_id_i;
            bnch_dest_o        <= dest_i;
            bnch_pred_taken_o  <= pred_taken;
            bnch_pred_target_o <= btb_target_i;
            wakeup_dest_o      <= dest_i;
        end
    end

endmodule

// ==== verilog/ex_pkg.sv ====
package ex_pkg;

    // ALU view of the opcode field
    typedef struct packed {
        logic [2:0] spare;
        logic       alt;                            // SUB over ADD, SRA over SRL
        logic [2:0] funct3;
    } ex_alu_opc_t;

    // Branch view of the opcode field
    typedef struct packed {
        logic [3:0] spare;
        logic [2:0] cond;                           // 0 BEQ, 1 BNE, 4 BLT, 5 BGE, 6 BLTU, 7 BGEU
    } ex_bnch_opc_t;

    // The same 7 bits decode as ALU function or as branch condition
    typedef union packed {
        ex_alu_opc_t  alu;
        ex_bnch_opc_t bnch;
    } ex_opc_u;

endpackage

// ==== verilog/ex_regfile.sv ====
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_regfile (
    input  logic               cpu_clock_i,
    input  logic               rst_i,
    input  logic [`PREG_W-1:0] rd1_idx_i,
    input  logic [`PREG_W-1:0] rd2_idx_i,
    output logic [`XLEN_W-1:0] rd1_data_o,
    output logic [`XLEN_W-1:0] rd2_data_o,
    input  logic               wr_en_i,
    input  logic [`PREG_W-1:0] wr_idx_i,
    input  logic [`XLEN_W-1:0] wr_data_i
);

    logic [`XLEN_W-1:0] regs [2**`PREG_W];

    always_ff @(posedge cpu_clock_i) begin
        if (rst_i) begin
            for (int i = 0; i < 2**`PREG_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_idx_i != '0)) begin   // Entry 0 stays zero
            regs[wr_idx_i] <= wr_data_i;
        end
    end

    assign rd1_data_o = regs[rd1_idx_i];
    assign rd2_data_o = regs[rd2_idx_i];

endmodule
